//--- hdl/cgra_pkg.sv
package cgra_pkg;

	// config bus fields.
	localparam int cfg_addr_w  = 32;
	localparam int cfg_field_w = 16; // tile field low, block field high.

	// block codes in config_addr[31:16].
	localparam logic [cfg_field_w-1:0] cfg_sb  = 16'd7;
	localparam logic [cfg_field_w-1:0] cfg_cb0 = 16'd6;
	localparam logic [cfg_field_w-1:0] cfg_cb1 = 16'd5;
	localparam logic [cfg_field_w-1:0] cfg_clb = 16'd4;

	// tile identities in config_addr[15:0].
	localparam logic [cfg_field_w-1:0] tile_id_0 = 16'd1;
	localparam logic [cfg_field_w-1:0] tile_id_1 = 16'd2;

	// track geometry. sides are west, south, east, north.
	localparam int num_sides  = 4;
	localparam int num_tracks = 4;

	// switch box, one selector per output track.
	localparam int sb_sel_w = 2;
	localparam int sb_cfg_w = num_sides * num_tracks * sb_sel_w;

	// connect box selector.
	localparam int cb_sel_w = 3;

	// logic block opcodes.
	localparam int clb_op_w = 2;
	localparam logic [clb_op_w-1:0] clb_and  = 2'd0;
	localparam logic [clb_op_w-1:0] clb_or   = 2'd1;
	localparam logic [clb_op_w-1:0] clb_xor  = 2'd2;
	localparam logic [clb_op_w-1:0] clb_nand = 2'd3;

endpackage

//--- hdl/config_decoder.sv
`timescale 1ns/100ps

module config_decoder
	import cgra_pkg::*;
	#(
	parameter logic [cfg_field_w-1:0] tile_id = 16'd0
	) (
	input  logic [cfg_addr_w-1:0] config_addr,
	output logic                  en_sb,
	output logic                  en_cb0,
	output logic                  en_cb1,
	output logic                  en_clb
	);

	logic                   tile_match;
	logic [cfg_field_w-1:0] block_code;

	assign tile_match = (config_addr[cfg_field_w-1:0] == tile_id);
	assign block_code = config_addr[cfg_addr_w-1:cfg_field_w];

	always_comb begin
		en_sb  = 1'b0;
		en_cb0 = 1'b0;
		en_cb1 = 1'b0;
		en_clb = 1'b0;
		if (tile_match) begin
			case (block_code)
				cfg_sb:  en_sb  = 1'b1;
				cfg_cb0: en_cb0 = 1'b1;
				cfg_cb1: en_cb1 = 1'b1;
				cfg_clb: en_clb = 1'b1;
				default: ; // unknown block, no write.
			endcase
		end
	end

endmodule

//--- hdl/connect_box.sv
`timescale 1ns/100ps

module connect_box
	import cgra_pkg::*;
	(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   config_en,
	input  logic [cb_sel_w-1:0]    config_data,
	input  logic [2**cb_sel_w-1:0] track_in,
	output logic                   block_out
	);

	logic [cb_sel_w-1:0] sel;

	// selector register.
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (config_en) begin
			sel <= config_data;
		end
	end

	// low half is the tile inputs, high half the switch box outputs.
	assign block_out = track_in[sel];

endmodule

//--- hdl/switch_box_bottom.sv
`timescale 1ns/100ps

module switch_box_bottom
	import cgra_pkg::*;
	(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  config_en,
	input  logic [sb_cfg_w-1:0]   config_data,
	input  logic                  pe_output,
	input  logic [num_tracks-1:0] in_west,
	input  logic [num_tracks-1:0] in_south,
	input  logic [num_tracks-1:0] in_east,
	input  logic [num_tracks-1:0] in_north,
	output logic [num_tracks-1:0] out_west,
	output logic [num_tracks-1:0] out_south,
	output logic [num_tracks-1:0] out_east,
	output logic [num_tracks-1:0] out_north
	);

	logic [sb_cfg_w-1:0]   sb_config;
	logic [num_tracks-1:0] side_in [num_sides];
	wire  [num_tracks-1:0] side_out [num_sides];

	always_ff @(posedge clk) begin
		if (reset) begin
			sb_config <= '0;
		end else if (config_en) begin
			sb_config <= config_data;
		end
	end

	// side order 0 west, 1 south, 2 east, 3 north.
	assign side_in[0] = in_west;
	assign side_in[1] = in_south;
	assign side_in[2] = in_east;
	assign side_in[3] = in_north;

	assign out_west  = side_out[0];
	assign out_south = side_out[1]; // tracks 1 to 3 stay in the tile.
	assign out_east  = side_out[2];
	assign out_north = side_out[3];

	for (genvar s = 0; s < num_sides; s++) begin : g_side
		// the three other sides, increasing order.
		localparam int src0 = (s > 0) ? 0 : 1;
		localparam int src1 = (s > 1) ? 1 : 2;
		localparam int src2 = (s > 2) ? 2 : 3;

		for (genvar t = 0; t < num_tracks; t++) begin : g_track
			localparam int idx = s * num_tracks + t;

			logic [sb_sel_w-1:0] sel;
			logic                route;

			assign sel = sb_config[idx*sb_sel_w +: sb_sel_w];

			always_comb begin
				case (sel)
					2'd0:    route = side_in[src0][t];
					2'd1:    route = side_in[src1][t];
					2'd2:    route = side_in[src2][t];
					default: route = pe_output; // logic block result.
				endcase
			end

			assign side_out[s][t] = route;
		end
	end

endmodule

//--- hdl/clb.sv
`timescale 1ns/100ps

module clb
	import cgra_pkg::*;
	(
	input  logic                clk,
	input  logic                reset,
	input  logic                config_en,
	input  logic [clb_op_w-1:0] config_data,
	input  logic                in0,
	input  logic                in1,
	output logic                out
	);

	logic [clb_op_w-1:0] opcode;
	logic                result;

	always_ff @(posedge clk) begin
		if (reset) begin
			opcode <= clb_and;
		end else if (config_en) begin
			opcode <= config_data;
		end
	end

	always_comb begin
		case (opcode)
			clb_and:  result = in0 & in1;
			clb_or:   result = in0 | in1;
			clb_xor:  result = in0 ^ in1;
			clb_nand: result = ~(in0 & in1);
			default:  result = 1'b0;
		endcase
	end

	// one cycle from operand to out.
	always_ff @(posedge clk) begin
		if (reset) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

endmodule

//--- hdl/pe_tile_bottom.sv
`timescale 1ns/100ps

module pe_tile_bottom
	import cgra_pkg::*;
	#(
	parameter logic [cfg_field_w-1:0] tile_id = tile_id_0
	) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [cfg_addr_w-1:0] config_addr,
	input  logic [sb_cfg_w-1:0]   config_data,
	input  logic [num_tracks-1:0] in_west,
	input  logic [num_tracks-1:0] in_south,
	input  logic [num_tracks-1:0] in_east,
	input  logic [num_tracks-1:0] in_north,
	output logic [num_tracks-1:0] out_west,
	output logic [num_tracks-1:0] out_east,
	output logic [num_tracks-1:0] out_north,
	output logic                  out_south0
	);

	logic                  en_sb;
	logic                  en_cb0;
	logic                  en_cb1;
	logic                  en_clb;
	logic                  op_0;
	logic                  op_1;
	logic                  pe_output;
	logic [num_tracks-1:0] sb_south; // only track 0 leaves the tile.

	config_decoder #(
		.tile_id(tile_id)
	) decoder (
		.config_addr(config_addr),
		.en_sb(en_sb),
		.en_cb0(en_cb0),
		.en_cb1(en_cb1),
		.en_clb(en_clb)
	);

	// operand a from the west side.
	connect_box cb0 (
		.clk(clk),
		.reset(reset),
		.config_en(en_cb0),
		.config_data(config_data[cb_sel_w-1:0]),
		.track_in({out_west, in_west}),
		.block_out(op_0)
	);

	// operand b from the south side.
	connect_box cb1 (
		.clk(clk),
		.reset(reset),
		.config_en(en_cb1),
		.config_data(config_data[cb_sel_w-1:0]),
		.track_in({sb_south, in_south}),
		.block_out(op_1)
	);

	switch_box_bottom sb (
		.clk(clk),
		.reset(reset),
		.config_en(en_sb),
		.config_data(config_data),
		.pe_output(pe_output),
		.in_west(in_west),
		.in_south(in_south),
		.in_east(in_east),
		.in_north(in_north),
		.out_west(out_west),
		.out_south(sb_south),
		.out_east(out_east),
		.out_north(out_north)
	);

	clb compute_block (
		.clk(clk),
		.reset(reset),
		.config_en(en_clb),
		.config_data(config_data[clb_op_w-1:0]),
		.in0(op_0),
		.in1(op_1),
		.out(pe_output)
	);

	assign out_south0 = sb_south[0];

endmodule

//--- hdl/cgra_row.sv
`timescale 1ns/100ps

module cgra_row
	import cgra_pkg::*;
	(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [cfg_addr_w-1:0] config_addr,
	input  logic [sb_cfg_w-1:0]   config_data,
	input  logic [num_tracks-1:0] west_in,
	input  logic [num_tracks-1:0] east_in,
	input  logic [num_tracks-1:0] north0_in,
	input  logic [num_tracks-1:0] north1_in,
	input  logic [num_tracks-1:0] south0_in,
	input  logic [num_tracks-1:0] south1_in,
	output logic [num_tracks-1:0] west_out,
	output logic [num_tracks-1:0] east_out,
	output logic [num_tracks-1:0] north0_out,
	output logic [num_tracks-1:0] north1_out,
	output logic                  south0_out,
	output logic                  south1_out
	);

	logic [num_tracks-1:0] east_bound; // tile0 east to tile1 west.
	logic [num_tracks-1:0] west_bound; // tile1 west to tile0 east.

	pe_tile_bottom #(
		.tile_id(tile_id_0)
	) tile0 (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_west(west_in),
		.in_south(south0_in),
		.in_east(west_bound),
		.in_north(north0_in),
		.out_west(west_out),
		.out_east(east_bound),
		.out_north(north0_out),
		.out_south0(south0_out)
	);

	pe_tile_bottom #(
		.tile_id(tile_id_1)
	) tile1 (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_west(east_bound),
		.in_south(south1_in),
		.in_east(east_in),
		.in_north(north1_in),
		.out_west(west_bound),
		.out_east(east_out),
		.out_north(north1_out),
		.out_south0(south1_out)
	);

endmodule

//--- verification/cgra_row_checker.sv
`timescale 1ns/100ps

module cgra_row_checker
	import cgra_pkg::*;
	(
	input logic                clk,
	input logic                reset,
	input logic                en_sb,
	input logic                en_cb0,
	input logic                en_cb1,
	input logic                en_clb,
	input logic                pe_output,
	input logic [sb_cfg_w-1:0] sb_word
	);

	int fail_count = 0; // failed assertions in this tile.

	one_enable: assert property (@(posedge clk) $onehot0({en_sb, en_cb0, en_cb1, en_clb}))
		else begin
			fail_count++;
			$error("two or more block enables active together");
		end

	// logic block output cleared one cycle after reset.
	clb_cleared: assert property (@(posedge clk) reset |=> !pe_output)
		else begin
			fail_count++;
			$error("logic block output not 0 after reset");
		end

	sb_holds: assert property (@(posedge clk) disable iff (reset) !en_sb |=> $stable(sb_word))
		else begin
			fail_count++;
			$error("switch box register changed without en_sb");
		end

endmodule

bind pe_tile_bottom cgra_row_checker tile_checks (
	.clk(clk),
	.reset(reset),
	.en_sb(en_sb),
	.en_cb0(en_cb0),
	.en_cb1(en_cb1),
	.en_clb(en_clb),
	.pe_output(pe_output),
	.sb_word(sb.sb_config)
);

//--- verification/cgra_row_scoreboard.sv
`timescale 1ns/100ps

module cgra_row_scoreboard
	import cgra_pkg::*;
	(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [cfg_addr_w-1:0] config_addr,
	input  logic [sb_cfg_w-1:0]   config_data,
	input  logic [num_tracks-1:0] west_in,
	input  logic [num_tracks-1:0] east_in,
	input  logic [num_tracks-1:0] north0_in,
	input  logic [num_tracks-1:0] north1_in,
	input  logic [num_tracks-1:0] south0_in,
	input  logic [num_tracks-1:0] south1_in,
	input  logic [num_tracks-1:0] west_out,
	input  logic [num_tracks-1:0] east_out,
	input  logic [num_tracks-1:0] north0_out,
	input  logic [num_tracks-1:0] north1_out,
	input  logic                  south0_out,
	input  logic                  south1_out,
	output int                    errors,
	output int                    checks
	);

	localparam int sample_delay = 3; // 1 ns ahead of the rising edge.

	logic [sb_cfg_w-1:0]   sb_cfg [2];
	logic [cb_sel_w-1:0]   cb0_sel [2];
	logic [cb_sel_w-1:0]   cb1_sel [2];
	logic [clb_op_w-1:0]   opcode [2];
	logic                  pe [2];
	logic                  op_a [2];
	logic                  op_b [2];
	logic [num_tracks-1:0] exp_west [2];
	logic [num_tracks-1:0] exp_south [2];
	logic [num_tracks-1:0] exp_east [2];
	logic [num_tracks-1:0] exp_north [2];
	logic                  model_valid;

	// codes 0 to 2 walk the other sides upward, 3 is the logic block.
	function automatic logic [num_tracks-1:0] route_side(
		input logic [sb_cfg_w-1:0]   cfg,
		input int                    side,
		input logic [num_tracks-1:0] w,
		input logic [num_tracks-1:0] s,
		input logic [num_tracks-1:0] e,
		input logic [num_tracks-1:0] n,
		input logic                  pe_out
	);
		logic [num_tracks-1:0] sides [num_sides];
		logic [num_tracks-1:0] res;
		logic [sb_sel_w-1:0]   code;
		logic [sb_sel_w-1:0]   rank;
		sides[0] = w;
		sides[1] = s;
		sides[2] = e;
		sides[3] = n;
		res = '0;
		for (int t = 0; t < num_tracks; t++) begin
			code = cfg[sb_sel_w * (side * num_tracks + t) +: sb_sel_w];
			rank = '0;
			if (code == 2'd3) begin
				res[t] = pe_out;
			end else begin
				for (int j = 0; j < num_sides; j++) begin
					if (j != side) begin
						if (rank == code) begin
							res[t] = sides[j][t];
						end
						rank = rank + 2'd1;
					end
				end
			end
		end
		return res;
	endfunction

	function automatic logic logic_op(input logic [clb_op_w-1:0] op, input logic a, input logic b);
		case (op)
			clb_and: return a & b;
			clb_or:  return a | b;
			clb_xor: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	task automatic evaluate();
		// a side never reads itself, so the two shared sides settle first.
		exp_east[0] = route_side(sb_cfg[0], 2, west_in, south0_in, 4'h0, north0_in, pe[0]);
		exp_west[1] = route_side(sb_cfg[1], 0, 4'h0, south1_in, east_in, north1_in, pe[1]);
		exp_west[0] = route_side(sb_cfg[0], 0, west_in, south0_in, exp_west[1], north0_in, pe[0]);
		exp_south[0] = route_side(sb_cfg[0], 1, west_in, south0_in, exp_west[1], north0_in, pe[0]);
		exp_north[0] = route_side(sb_cfg[0], 3, west_in, south0_in, exp_west[1], north0_in, pe[0]);
		exp_east[1] = route_side(sb_cfg[1], 2, exp_east[0], south1_in, east_in, north1_in, pe[1]);
		exp_south[1] = route_side(sb_cfg[1], 1, exp_east[0], south1_in, east_in, north1_in, pe[1]);
		exp_north[1] = route_side(sb_cfg[1], 3, exp_east[0], south1_in, east_in, north1_in, pe[1]);
		// high code bit picks the switch box side.
		op_a[0] = cb0_sel[0][2] ? exp_west[0][cb0_sel[0][1:0]] : west_in[cb0_sel[0][1:0]];
		op_b[0] = cb1_sel[0][2] ? exp_south[0][cb1_sel[0][1:0]] : south0_in[cb1_sel[0][1:0]];
		op_a[1] = cb0_sel[1][2] ? exp_west[1][cb0_sel[1][1:0]] : exp_east[0][cb0_sel[1][1:0]];
		op_b[1] = cb1_sel[1][2] ? exp_south[1][cb1_sel[1][1:0]] : south1_in[cb1_sel[1][1:0]];
	endtask

	task automatic update_state();
		int k;
		k = (config_addr[15:0] == tile_id_0) ? 0 : (config_addr[15:0] == tile_id_1) ? 1 : -1;
		for (int i = 0; i < 2; i++) begin
			pe[i] = reset ? 1'b0 : logic_op(opcode[i], op_a[i], op_b[i]);
			if (reset) begin
				sb_cfg[i] = '0;
				cb0_sel[i] = '0;
				cb1_sel[i] = '0;
				opcode[i] = clb_and;
			end else if (k == i) begin
				case (config_addr[31:16])
					cfg_sb:  sb_cfg[i] = config_data;
					cfg_cb0: cb0_sel[i] = config_data[cb_sel_w-1:0];
					cfg_cb1: cb1_sel[i] = config_data[cb_sel_w-1:0];
					cfg_clb: opcode[i] = config_data[clb_op_w-1:0];
					default: ;
				endcase
			end
		end
		if (reset) begin
			model_valid = 1'b1;
		end
	endtask

	task automatic check_port(input string name, input logic [3:0] expected, input logic [3:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		model_valid = 1'b0;
		forever begin
			@(posedge clk);
			evaluate();
			update_state();
			@(negedge clk);
			#(sample_delay);
			if (model_valid) begin
				evaluate();
				check_port("west_out", exp_west[0], west_out);
				check_port("east_out", exp_east[1], east_out);
				check_port("north0_out", exp_north[0], north0_out);
				check_port("north1_out", exp_north[1], north1_out);
				check_port("south0_out", {3'b0, exp_south[0][0]}, {3'b0, south0_out});
				check_port("south1_out", {3'b0, exp_south[1][0]}, {3'b0, south1_out});
			end
		end
	end

endmodule

//--- verification/cgra_row_tb.sv
`timescale 1ns/100ps

module cgra_row_tb
	import cgra_pkg::*;
	();

	localparam int clk_period    = 8;
	localparam int route_iters   = 10;
	localparam int logic_iters   = 12;
	localparam int decode_writes = 40;
	localparam int test_cycles   = 2 + 20 + route_iters * 10 + decode_writes + 2
		+ logic_iters * 14 + 40 + 5;
	localparam int margin_cycles = 50;

	logic                  clk;
	logic                  reset;
	logic [cfg_addr_w-1:0] config_addr;
	logic [sb_cfg_w-1:0]   config_data;
	logic [num_tracks-1:0] west_in;
	logic [num_tracks-1:0] east_in;
	logic [num_tracks-1:0] north0_in;
	logic [num_tracks-1:0] north1_in;
	logic [num_tracks-1:0] south0_in;
	logic [num_tracks-1:0] south1_in;
	logic [num_tracks-1:0] west_out;
	logic [num_tracks-1:0] east_out;
	logic [num_tracks-1:0] north0_out;
	logic [num_tracks-1:0] north1_out;
	logic                  south0_out;
	logic                  south1_out;
	int                    seed;
	int                    errors;
	int                    checks;
	int                    test_num;
	int                    start_errors;
	int                    assert_fails;

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	cgra_row dut (.*);

	cgra_row_scoreboard scoreboard (.*);

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] set_field(input logic [31:0] word, input int side,
		input int track, input logic [1:0] code);
		logic [31:0] res;
		res = word;
		res[sb_sel_w * (side * num_tracks + track) +: sb_sel_w] = code;
		return res;
	endfunction

	// random routing with the logic block on about half the outputs.
	function automatic logic [31:0] word_with_pe();
		logic [31:0] word;
		logic [31:0] mask;
		word = rand32();
		mask = rand32();
		for (int i = 0; i < 16; i++) begin
			if (mask[i]) begin
				word[2 * i +: 2] = 2'd3;
			end
		end
		return word;
	endfunction

	task automatic drive_tracks();
		logic [31:0] r;
		r = rand32();
		west_in = r[3:0];
		east_in = r[7:4];
		north0_in = r[11:8];
		north1_in = r[15:12];
		south0_in = r[19:16];
		south1_in = r[23:20];
	endtask

	task automatic write_cfg(input logic [15:0] tile, input logic [15:0] block,
		input logic [31:0] data);
		@(negedge clk);
		config_addr = {block, tile};
		config_data = data;
	endtask

	task automatic run_cycles(input int n, input bit new_tracks);
		repeat (n) begin
			@(negedge clk);
			config_addr = '0; // tile 0 matches nothing.
			config_data = rand32();
			if (new_tracks) begin
				drive_tracks();
			end
		end
	endtask

	task automatic begin_test();
		start_errors = errors;
		test_num++;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		if (errors == start_errors) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d mismatches", test_num, name, errors - start_errors);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] word0;
		logic [31:0] word1;
		logic [15:0] tile;
		logic [15:0] block;
		int          track;
		seed = 72529;
		test_num = 0;
		reset = 1'b1;
		config_addr = '0;
		config_data = '0;
		drive_tracks();
		repeat (2) @(negedge clk);
		reset = 1'b0;

		begin_test();
		run_cycles(20, 1'b1);
		end_test("reset state");

		begin_test();
		repeat (route_iters) begin
			write_cfg(tile_id_0, cfg_sb, rand32());
			write_cfg(tile_id_1, cfg_sb, rand32());
			run_cycles(8, 1'b1);
		end
		end_test("switch box routing");

		// tracks held, so a wrong write would show up as a change.
		begin_test();
		for (int i = 0; i < decode_writes; i++) begin
			r = rand32();
			if (i % 2 == 0) begin
				tile = r[15:0];
				if (tile == tile_id_0 || tile == tile_id_1) begin
					tile = tile ^ 16'h8000;
				end
				block = cfg_clb + {14'd0, r[17:16]};
			end else begin
				tile = r[16] ? tile_id_1 : tile_id_0;
				block = r[31:16];
				if (block[15:2] == 14'd1) begin
					block[8] = 1'b1; // out of the 4 to 7 range.
				end
			end
			write_cfg(tile, block, rand32());
		end
		run_cycles(2, 1'b0);
		end_test("address decoding");

		begin_test();
		repeat (logic_iters) begin
			write_cfg(tile_id_0, cfg_sb, word_with_pe());
			write_cfg(tile_id_1, cfg_sb, word_with_pe());
			write_cfg(tile_id_0, cfg_cb0, rand32());
			write_cfg(tile_id_0, cfg_cb1, rand32());
			write_cfg(tile_id_1, cfg_cb0, rand32());
			write_cfg(tile_id_1, cfg_cb1, rand32());
			write_cfg(tile_id_0, cfg_clb, rand32());
			write_cfg(tile_id_1, cfg_clb, rand32());
			run_cycles(6, 1'b1);
		end
		end_test("operand selection and logic");

		begin_test();
		word0 = rand32();
		word1 = rand32();
		for (int t = 0; t < num_tracks; t++) begin
			word0 = set_field(word0, 2, t, 2'd0); // east takes west.
			word1 = set_field(word1, 2, t, 2'd0);
		end
		write_cfg(tile_id_0, cfg_sb, word0);
		write_cfg(tile_id_1, cfg_sb, word1);
		run_cycles(10, 1'b1);
		// tile 0 result crosses on one track into tile 1 operand a.
		r = rand32();
		track = {30'd0, r[1:0]};
		word0 = set_field(word0, 2, track, 2'd3);
		word1 = set_field(word1, 1, 0, 2'd3);
		for (int t = 0; t < num_tracks; t++) begin
			word1 = set_field(word1, 3, t, 2'd3);
		end
		write_cfg(tile_id_0, cfg_sb, word0);
		write_cfg(tile_id_1, cfg_sb, word1);
		write_cfg(tile_id_0, cfg_cb0, rand32());
		write_cfg(tile_id_0, cfg_cb1, rand32());
		write_cfg(tile_id_0, cfg_clb, rand32());
		write_cfg(tile_id_1, cfg_cb0, {30'd0, r[1:0]});
		write_cfg(tile_id_1, cfg_cb1, rand32());
		write_cfg(tile_id_1, cfg_clb, {30'd0, clb_xor});
		run_cycles(20, 1'b1);
		end_test("cross-tile paths");

		#1;
		assert_fails = dut.tile0.tile_checks.fail_count + dut.tile1.tile_checks.fail_count;
		$display("%0d tests, %0d checks, %0d mismatches, %0d assertion failures",
			test_num, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0 && checks > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#((test_cycles + margin_cycles) * clk_period);
		$display("timeout: the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- filelist.f
hdl/cgra_pkg.sv
hdl/config_decoder.sv
hdl/connect_box.sv
hdl/switch_box_bottom.sv
hdl/clb.sv
hdl/pe_tile_bottom.sv
hdl/cgra_row.sv
verification/cgra_row_checker.sv
verification/cgra_row_scoreboard.sv
verification/cgra_row_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the row testbench with verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cgra_row_tb -f filelist.f \
	-o cgra_row_sim || exit 1
out=$(./obj_dir/cgra_row_sim)
echo "$out"
echo "$out" | grep -qF "All tests passed!" && exit 0 || exit 1
